// File: cpuCore.f
+incdir+include
rtl/cpuPkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/fetchUnit.sv
rtl/dataPath.sv
rtl/cpuCore.sv
verif/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=cpuCoreSim

verilator --binary --timing -j 0 \
	--timescale 1ns/1ps \
	--top-module cpuCoreTb \
	-f cpuCore.f \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

exit 0

// File: verif/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuCoreTb;

	import cpuPkg::*;

	localparam int NumInstr   = 3000;
	localparam int RunLimit   = 4000;	// Cycles allowed for the main run
	localparam int ResetLimit = 20;		// ns allowed for pc to clear
	localparam logic [`CPU_DATA_W-1:0] FillKey = 16'hA5C3;

	logic clk;
	logic rstN;
	logic [`CPU_DATA_W-1:0] instruction;
	logic [`CPU_DATA_W-1:0] dReadData;
	wire  [`CPU_DATA_W-1:0] pc;
	wire  [`CPU_DATA_W-1:0] dAddr;
	wire  [`CPU_DATA_W-1:0] dWriteData;
	wire  memWE;

	// Reference model state
	logic [`CPU_DATA_W-1:0] modelRegs [`CPU_NUM_REGS];
	logic modelC;
	logic modelZ;
	logic [`CPU_DATA_W-1:0] modelPc;
	logic [`CPU_DATA_W-1:0] modelMem [logic [`CPU_DATA_W-1:0]];

	// Memories seen by the DUT
	logic [`CPU_DATA_W-1:0] busMem [logic [`CPU_DATA_W-1:0]];
	logic [`CPU_DATA_W-1:0] instrMem [logic [`CPU_DATA_W-1:0]];

	cpuCore uut (
		.clk(clk), .rstN(rstN),
		.pc(pc), .instruction(instruction),
		.dAddr(dAddr), .dWriteData(dWriteData), .dReadData(dReadData),
		.memWE(memWE)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;	// 4 ns period

	// Data memory takes the store on the closing edge
	always @(posedge clk) begin
		if (rstN && memWE)
			busMem[dAddr] = dWriteData;
	end

	function automatic logic [`CPU_DATA_W-1:0] busRead(input logic [`CPU_DATA_W-1:0] addr);
		if (busMem.exists(addr))
			return busMem[addr];
		return addr ^ FillKey;	// Unwritten word
	endfunction

	function automatic logic [`CPU_DATA_W-1:0] modelRead(input logic [`CPU_DATA_W-1:0] addr);
		if (modelMem.exists(addr))
			return modelMem[addr];
		return addr ^ FillKey;
	endfunction

	// Weighted opcode pick, stores and branches on the heavy side
	function automatic logic [`CPU_DATA_W-1:0] randomInstr();
		int pick;
		logic [3:0] op;
		pick = $urandom_range(0, 99);
		if (pick < 14)
			op = opAdd;
		else if (pick < 24)
			op = opMv;
		else if (pick < 38)
			op = opLdImm;
		else if (pick < 48)
			op = opLdInd;
		else if (pick < 66)
			op = opStInd;
		else if (pick < 76)
			op = opBrImm;
		else if (pick < 84)
			op = opBrInd;
		else if (pick < 92)
			op = 4'($urandom_range(2, 9));	// Unlisted NOPs
		else
			op = opUnused;
		return {op, 12'($urandom)};
	endfunction

	// Revisited words are sometimes replaced so tight loops break up
	function automatic logic [`CPU_DATA_W-1:0] fetchInstr(input logic [`CPU_DATA_W-1:0] addr);
		if (!instrMem.exists(addr) || $urandom_range(0, 3) == 0)
			instrMem[addr] = randomInstr();
		return instrMem[addr];
	endfunction

	task automatic check(input string name, input logic [`CPU_DATA_W-1:0] actual,
			input logic [`CPU_DATA_W-1:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One ISA step, strobes checked against old state first
	task automatic executeModel(input logic [`CPU_DATA_W-1:0] instr);
		opcodeT op;
		logic [1:0] rd;
		logic [1:0] rs1;
		logic [1:0] rs2;
		logic [`CPU_DATA_W-1:0] payload;
		logic [`CPU_DATA_W:0] sum;
		logic taken;
		logic [`CPU_DATA_W-1:0] nextPc;
		op      = opcodeT'(instr[15:12]);
		rd      = instr[11:10];
		rs1     = instr[9:8];
		rs2     = instr[7:6];
		payload = {8'h00, instr[7:0]};	// Zero extended
		// Bit 11 picks zero over carry, bit 10 is the wanted value
		taken  = instr[11] ? (instr[10] == modelZ) : (instr[10] == modelC);
		nextPc = modelPc + 16'd1;

		check("memWE", 16'(memWE), 16'(op == opStInd));
		if (op == opStInd) begin
			check("dAddr", dAddr, modelRegs[rs1]);
			check("dWriteData", dWriteData, modelRegs[rs2]);
		end

		case (op)
			opAdd: begin
				sum = {1'b0, modelRegs[rs1]} + {1'b0, modelRegs[rs2]};
				modelRegs[rd] = sum[`CPU_DATA_W-1:0];
				modelC = sum[`CPU_DATA_W];
				modelZ = (sum[`CPU_DATA_W-1:0] == '0);
			end
			opMv:    modelRegs[rd] = modelRegs[rs1];
			opLdImm: modelRegs[rd] = payload;
			opLdInd: modelRegs[rd] = modelRead(modelRegs[rs1]);
			opStInd: modelMem[modelRegs[rs1]] = modelRegs[rs2];
			opBrImm: begin
				if (taken)
					nextPc = payload;
			end
			opBrInd: begin
				if (taken)
					nextPc = modelRegs[rs1];
			end
			default: begin	// 2..9 and 12, PC only
			end
		endcase
		modelPc = nextPc;
	endtask

	initial begin
		int seedValue;
		int waitNs;
		int cycles;
		int done;
		logic [`CPU_DATA_W-1:0] instr;
		seedValue   = $urandom(32'h7847);
		rstN        = 1'b0;
		instruction = 16'h2000;	// NOP held through reset
		dReadData   = '0;
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			modelRegs[i] = '0;
		modelC  = 1'b0;
		modelZ  = 1'b0;
		modelPc = `CPU_RESET_PC;

		// Async reset should clear pc right away
		waitNs = 0;
		while (pc !== `CPU_RESET_PC) begin
			if (waitNs >= ResetLimit) begin
				$display("tests failed");
				$fatal(1, "pc never reached its reset value during reset");
			end
			#1;
			waitNs++;
		end
		for (int i = 0; i < 3; i++)
			@(posedge clk);
		#1;
		rstN = 1'b1;
		check("pc", pc, `CPU_RESET_PC);
		check("memWE", 16'(memWE), 16'h0000);

		cycles = 0;
		done   = 0;
		while (done < NumInstr) begin
			if (cycles >= RunLimit) begin
				$display("tests failed");
				$fatal(1, "Main run exceeded its cycle limit");
			end
			check("pc", pc, modelPc);
			instr = fetchInstr(modelPc);
			instruction = instr;
			#1;
			dReadData = busRead(dAddr);	// Settled address, same cycle
			executeModel(instr);
			@(posedge clk);
			#1;
			cycles++;
			done++;
		end
		check("pc", pc, modelPc);	// Last instruction's next PC

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuCore (
	input  wire clk,
	input  wire rstN,

	// Instruction side, fetched combinationally at pc
	output logic [`CPU_DATA_W-1:0] pc,
	input  wire [`CPU_DATA_W-1:0] instruction,

	// Data side
	output logic [`CPU_DATA_W-1:0] dAddr,
	output logic [`CPU_DATA_W-1:0] dWriteData,
	input  wire [`CPU_DATA_W-1:0] dReadData,
	output logic memWE		// Level strobe, store this cycle
);

	import cpuPkg::*;

	// Decoder controls
	pcSelT nextPCSel;
	aluOpT aluOp;
	logic regDataInSource;
	logic immData;
	logic regFileWE;
	logic flagsWE;
	logic dAddrSel;
	logic [$clog2(`CPU_NUM_REGS)-1:0] regDst;
	logic [$clog2(`CPU_NUM_REGS)-1:0] regSrc1;
	logic [$clog2(`CPU_NUM_REGS)-1:0] regSrc2;
	logic [`CPU_DATA_W-1:0] instrData;

	// Operands and results
	logic [`CPU_DATA_W-1:0] rs1Data;
	logic [`CPU_DATA_W-1:0] rs2Data;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic cFlag;
	logic zFlag;

	decoder uDecoder (
		.instruction(instruction), .cFlag(cFlag), .zFlag(zFlag),
		.nextPCSel(nextPCSel), .regDataInSource(regDataInSource), .immData(immData),
		.regDst(regDst), .regFileWE(regFileWE), .regSrc1(regSrc1), .regSrc2(regSrc2),
		.aluOp(aluOp), .flagsWE(flagsWE), .memWE(memWE), .dAddrSel(dAddrSel),
		.instrData(instrData)
	);

	fetchUnit uFetch (
		.clk(clk), .rstN(rstN), .nextPCSel(nextPCSel),
		.instrData(instrData), .rs1Data(rs1Data), .pc(pc)
	);

	dataPath uDataPath (
		.clk(clk), .rstN(rstN),
		.regDst(regDst), .regSrc1(regSrc1), .regSrc2(regSrc2), .regFileWE(regFileWE),
		.regDataInSource(regDataInSource), .immData(immData), .dAddrSel(dAddrSel),
		.instrData(instrData), .aluResult(aluResult), .dReadData(dReadData),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .dAddr(dAddr), .dWriteData(dWriteData)
	);

	alu uAlu (
		.clk(clk), .rstN(rstN), .aluOp(aluOp), .flagsWE(flagsWE),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.aluResult(aluResult), .cFlag(cFlag), .zFlag(zFlag)
	);

endmodule

`default_nettype wire

// File: rtl/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module dataPath (
	input  wire clk,
	input  wire rstN,

	// Register file addressing
	input  wire [$clog2(`CPU_NUM_REGS)-1:0] regDst,
	input  wire [$clog2(`CPU_NUM_REGS)-1:0] regSrc1,
	input  wire [$clog2(`CPU_NUM_REGS)-1:0] regSrc2,
	input  wire regFileWE,

	// Write-back and address selects
	input  wire regDataInSource,
	input  wire immData,
	input  wire dAddrSel,

	input  wire [`CPU_DATA_W-1:0] instrData,
	input  wire [`CPU_DATA_W-1:0] aluResult,
	input  wire [`CPU_DATA_W-1:0] dReadData,

	output logic [`CPU_DATA_W-1:0] rs1Data,
	output logic [`CPU_DATA_W-1:0] rs2Data,
	output logic [`CPU_DATA_W-1:0] dAddr,
	output logic [`CPU_DATA_W-1:0] dWriteData
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];
	logic [`CPU_DATA_W-1:0] wbData;

	// Two async read ports
	assign rs1Data = regs[regSrc1];
	assign rs2Data = regs[regSrc2];

	// Write-back source, immediate wins over memory
	always_comb begin
		if (immData)
			wbData = instrData;
		else if (regDataInSource)
			wbData = dReadData;	// Load result
		else
			wbData = aluResult;	// ADD or MV
	end

	// Architectural registers start at zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (regFileWE) begin
			regs[regDst] <= wbData;
		end
	end

	// Data address, rs1 for indirect, else instrData
	assign dAddr = dAddrSel ? rs1Data : instrData;

	// Stores always write rs2
	assign dWriteData = rs2Data;

endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetchUnit (
	input  wire clk,
	input  wire rstN,

	input  wire cpuPkg::pcSelT nextPCSel,
	input  wire [`CPU_DATA_W-1:0] instrData,	// Immediate target
	input  wire [`CPU_DATA_W-1:0] rs1Data,		// Register target

	output logic [`CPU_DATA_W-1:0] pc
);

	import cpuPkg::*;

	logic [`CPU_DATA_W-1:0] pcNext;

	// Next PC mux
	always_comb begin
		case (nextPCSel)
			pcImm:   pcNext = instrData;
			pcReg:   pcNext = rs1Data;
			default: pcNext = pc + `CPU_DATA_W'(1);	// Wraps at top of memory
		endcase
	end

	// One instruction per clock, PC moves every edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `CPU_RESET_PC;
		else
			pc <= pcNext;
	end

endmodule

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decoder (
	input  wire [`CPU_DATA_W-1:0] instruction,

	input  wire cFlag,	// Carry, for branch test
	input  wire zFlag,	// Zero, for branch test
	output cpuPkg::pcSelT nextPCSel,

	output logic regDataInSource,	// Write back from memory
	output logic immData,			// Write back from instrData
	output logic [$clog2(`CPU_NUM_REGS)-1:0] regDst,
	output logic regFileWE,
	output logic [$clog2(`CPU_NUM_REGS)-1:0] regSrc1,
	output logic [$clog2(`CPU_NUM_REGS)-1:0] regSrc2,

	output cpuPkg::aluOpT aluOp,
	output logic flagsWE,			// ADD only

	output logic memWE,
	output logic dAddrSel,			// Register-based data address
	output logic [`CPU_DATA_W-1:0] instrData
);

	import cpuPkg::*;

	opcodeT opcode;
	logic [7:0] payload;
	logic brFlagSel;	// 0 carry, 1 zero
	logic brWant;		// Flag value that takes the branch
	logic brTaken;

	assign opcode = opcodeT'(instruction[15:12]);

	// Register fields sit at fixed positions
	// Unused ones are harmless since strobes stay low
	assign regDst  = instruction[11:10];
	assign regSrc1 = instruction[9:8];
	assign regSrc2 = instruction[7:6];

	// Branch condition overlaps rd field
	assign brFlagSel = instruction[11];
	assign brWant    = instruction[10];

	assign payload = instruction[7:0];

	// Condition check shared by both branch forms
	assign brTaken = brFlagSel ? (brWant == zFlag) : (brWant == cFlag);

	always_comb begin
		// Everything off unless the opcode says otherwise
		nextPCSel       = pcIncr;
		regDataInSource = 1'b0;
		immData         = 1'b0;
		regFileWE       = 1'b0;
		aluOp           = aluAdd;
		flagsWE         = 1'b0;
		memWE           = 1'b0;
		dAddrSel        = 1'b0;
		instrData       = '0;

		case (opcode)
			opAdd: begin
				regFileWE = 1'b1;
				aluOp     = aluAdd;
				flagsWE   = 1'b1;	// Only op touching C and Z
			end

			opMv: begin
				regFileWE = 1'b1;
				aluOp     = aluPass;	// rs1 through the ALU
			end

			opLdImm: begin
				immData   = 1'b1;
				regFileWE = 1'b1;
				instrData = {{(`CPU_DATA_W-8){1'b0}}, payload};	// Zero extend
			end

			opLdInd: begin
				dAddrSel        = 1'b1;	// Address from rs1
				regDataInSource = 1'b1;	// Load data to rd
				regFileWE       = 1'b1;
			end

			opStInd: begin
				dAddrSel = 1'b1;
				memWE    = 1'b1;	// rs2 goes out as write data
			end

			opBrImm: begin
				if (brTaken) begin
					nextPCSel = pcImm;
					instrData = {{(`CPU_DATA_W-8){1'b0}}, payload};
				end
			end

			opBrInd: begin
				if (brTaken)
					nextPCSel = pcReg;	// Jump target in rs1
			end

			// opUnused and 2..9 just fall through to PC + 1
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu (
	input  wire clk,
	input  wire rstN,

	input  wire cpuPkg::aluOpT aluOp,
	input  wire flagsWE,	// Capture flags this edge
	input  wire [`CPU_DATA_W-1:0] rs1Data,
	input  wire [`CPU_DATA_W-1:0] rs2Data,

	output logic [`CPU_DATA_W-1:0] aluResult,
	output logic cFlag,
	output logic zFlag
);

	import cpuPkg::*;

	logic [`CPU_DATA_W-1:0] sum;
	logic carryOut;

	// Adder with carry out of the top bit
	assign {carryOut, sum} = {1'b0, rs1Data} + {1'b0, rs2Data};

	always_comb begin
		case (aluOp)
			aluPass: aluResult = rs1Data;	// MV path
			default: aluResult = sum;
		endcase
	end

	// Flags follow the sum, not the selected result
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagsWE) begin
			cFlag <= carryOut;
			zFlag <= (sum == '0);
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Instruction opcodes, bits 15:12
	// Values 2 to 9 are not listed and act as NOPs
	typedef enum logic [3:0] {
		opAdd    = 4'd0,	// rd = rs1 + rs2, sets flags
		opMv     = 4'd1,	// rd = rs1
		opLdImm  = 4'd10,	// rd = payload
		opLdInd  = 4'd11,	// rd = mem[rs1]
		opUnused = 4'd12,
		opStInd  = 4'd13,	// mem[rs1] = rs2
		opBrImm  = 4'd14,	// Conditional jump to payload
		opBrInd  = 4'd15	// Conditional jump to rs1
	} opcodeT;

	// ALU function
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluPass = 4'd15		// Forward rs1 untouched
	} aluOpT;

	// Next PC source
	typedef enum logic [1:0] {
		pcIncr = 2'd0,		// Sequential
		pcImm  = 2'd1,		// From instrData
		pcReg  = 2'd2		// From rs1
	} pcSelT;

endpackage

`default_nettype wire

// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Machine word, also PC and data address width
`define CPU_DATA_W 16

// Register file depth
// Instruction fields hold two-bit indices
`define CPU_NUM_REGS 4

// First fetch address out of reset
`define CPU_RESET_PC 16'h0000

`endif
